// File: Bender.yml
package:
  name: fetch_cur_luma

export_include_dirs:
  - rtl

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/cur_geom_pkg.sv
      - rtl/cur_role_pkg.sv
      - rtl/cur_bank_if.sv
      - rtl/cur_rotate_ctrl.sv
      - rtl/cur_bank_array.sv
      - rtl/cur_pel_route.sv
      - rtl/fetch_cur_luma.sv

  - target: test
    include_dirs:
      - rtl
    files:
      - verification/tb_fetch_cur_luma.sv

// File: compile.f
+incdir+rtl
rtl/cur_geom_pkg.sv
rtl/cur_role_pkg.sv
rtl/cur_bank_if.sv
rtl/cur_rotate_ctrl.sv
rtl/cur_bank_array.sv
rtl/cur_pel_route.sv
rtl/fetch_cur_luma.sv
verification/tb_fetch_cur_luma.sv

// File: rtl/cur_bank_array.sv
`timescale 1ns/100ps

`include "cur_cfg.svh"

module cur_bank_array
    import cur_geom_pkg::*;
    import cur_role_pkg::*;
(
    input  logic       clk,
    input  bank_role_e bank_role_i [`CUR_NUM_BANKS],

    // external LCU load
    input  logic       load_valid_i,
    input  bank_addr_t load_addr_i,
    input  blk_word_t  load_data_i,

    // consumer read requests
    input  logic       ime_ren_i,
    input  logic       fme_ren_i,
    input  logic       db_ren_i,
    input  blk_coord_t ime_x_i,
    input  blk_coord_t ime_y_i,
    input  blk_coord_t fme_x_i,
    input  blk_coord_t fme_y_i,
    input  blk_coord_t db_x_i,
    input  blk_coord_t db_y_i,

    cur_bank_if.steer  bank_steer [`CUR_NUM_BANKS],
    cur_bank_if.store  bank_store [`CUR_NUM_BANKS]
);

    localparam int BANK_WORDS = `CUR_BLKS_PER_SIDE * `CUR_BLKS_PER_SIDE;

    bank_addr_t ime_addr;
    bank_addr_t fme_addr;
    bank_addr_t db_addr;

    assign ime_addr = blk_addr(ime_x_i, ime_y_i);
    assign fme_addr = blk_addr(fme_x_i, fme_y_i);
    assign db_addr  = blk_addr(db_x_i, db_y_i);

    for (genvar g = 0; g < `CUR_NUM_BANKS; g++) begin : g_bank

        // ****************************************
        // port steering by role
        // ****************************************

        always_comb begin
            bank_steer[g].wen   = 1'b0;
            bank_steer[g].waddr = '0;
            bank_steer[g].wdata = '0;
            bank_steer[g].ren   = 1'b0;
            bank_steer[g].raddr = '0;
            unique case (bank_role_i[g])
                ROLE_LOAD: begin
                    bank_steer[g].wen   = load_valid_i;
                    bank_steer[g].waddr = load_addr_i;
                    bank_steer[g].wdata = load_data_i;
                end
                ROLE_IME: begin
                    bank_steer[g].ren   = ime_ren_i;
                    bank_steer[g].raddr = ime_addr;
                end
                ROLE_FME: begin
                    bank_steer[g].ren   = fme_ren_i;
                    bank_steer[g].raddr = fme_addr;
                end
                ROLE_DB: begin
                    bank_steer[g].ren   = db_ren_i;
                    bank_steer[g].raddr = db_addr;
                end
            endcase
        end

        // ****************************************
        // storage, one LCU per bank
        // ****************************************

        blk_word_t mem [BANK_WORDS];

        // load bank never reads, so no read/write collision
        always_ff @(posedge clk) begin
            if (bank_store[g].wen) begin
                mem[bank_store[g].waddr] <= bank_store[g].wdata;
            end
            if (bank_store[g].ren) begin
                bank_store[g].rdata <= mem[bank_store[g].raddr];   // holds otherwise
            end
        end

    end

endmodule

// File: rtl/cur_bank_if.sv
`timescale 1ns/100ps

interface cur_bank_if import cur_geom_pkg::*; ();

    // write side, only active while the bank loads
    logic       wen;
    bank_addr_t waddr;
    blk_word_t  wdata;

    // read side for whichever consumer owns the bank
    logic       ren;
    bank_addr_t raddr;
    blk_word_t  rdata;      // one cycle after ren

    // port steering drives the controls
    modport steer (
        output wen, waddr, wdata, ren, raddr
    );

    // bank storage
    modport store (
        input  wen, waddr, wdata, ren, raddr,
        output rdata
    );

    // read data return path
    modport sink (
        input rdata
    );

endinterface

// File: rtl/cur_cfg.svh
`ifndef CUR_CFG_SVH
`define CUR_CFG_SVH

// ****************************************
// luma LCU geometry
// ****************************************

// bits per luma sample
`define CUR_PIXEL_W        8

// one 4x4 block per bank word
`define CUR_BLK_PIXELS     16

// 64 pixels / 4 per block
`define CUR_BLKS_PER_SIDE  16

// load + ime + fme + db
`define CUR_NUM_BANKS      4

`endif

// File: rtl/cur_geom_pkg.sv
`include "cur_cfg.svh"

package cur_geom_pkg;

    // single luma sample
    typedef logic [`CUR_PIXEL_W-1:0] pixel_t;

    // one 4x4 block, pixel 0 in the low byte
    typedef pixel_t [`CUR_BLK_PIXELS-1:0] blk_word_t;

    // block column or row inside the LCU
    typedef logic [$clog2(`CUR_BLKS_PER_SIDE)-1:0] blk_coord_t;

    // word address inside one bank
    typedef logic [$clog2(`CUR_BLKS_PER_SIDE*`CUR_BLKS_PER_SIDE)-1:0] bank_addr_t;

    // raster order of 4x4 blocks, y * 16 + x
    function automatic bank_addr_t blk_addr(blk_coord_t x, blk_coord_t y);
        bank_addr_t addr;
        addr = {y, x};
        return addr;
    endfunction

endpackage

// File: rtl/cur_pel_route.sv
`timescale 1ns/100ps

`include "cur_cfg.svh"

module cur_pel_route
    import cur_geom_pkg::*;
    import cur_role_pkg::*;
(
    input  logic      clk,
    input  logic      rstn,
    input  logic      ime_ren_i,
    input  logic      fme_ren_i,
    input  logic      db_ren_i,
    input  bank_idx_t ime_bank_i,
    input  bank_idx_t fme_bank_i,
    input  bank_idx_t db_bank_i,
    cur_bank_if.sink  bank_sink [`CUR_NUM_BANKS],
    output blk_word_t ime_pel_o,
    output blk_word_t fme_pel_o,
    output blk_word_t db_pel_o,
    output logic      ime_valid_o,
    output logic      fme_valid_o,
    output logic      db_valid_o
);

    // consumer order ime, fme, db
    localparam int NUM_CONS = 3;

    logic      ren      [NUM_CONS];
    bank_idx_t bank     [NUM_CONS];
    logic      valid_q  [NUM_CONS];
    bank_idx_t sel_q    [NUM_CONS];
    blk_word_t bank_rd  [`CUR_NUM_BANKS];

    assign ren  = '{ime_ren_i, fme_ren_i, db_ren_i};
    assign bank = '{ime_bank_i, fme_bank_i, db_bank_i};

    // flatten the interface array so it can be indexed at run time
    for (genvar g = 0; g < `CUR_NUM_BANKS; g++) begin : g_sink
        assign bank_rd[g] = bank_sink[g].rdata;
    end

    // select follows the read, not the current rotation
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int c = 0; c < NUM_CONS; c++) begin
                valid_q[c] <= 1'b0;
                sel_q[c]   <= '0;
            end
        end else begin
            for (int c = 0; c < NUM_CONS; c++) begin
                valid_q[c] <= ren[c];
                if (ren[c]) begin
                    sel_q[c] <= bank[c];
                end
            end
        end
    end

    assign ime_pel_o   = bank_rd[sel_q[0]];
    assign fme_pel_o   = bank_rd[sel_q[1]];
    assign db_pel_o    = bank_rd[sel_q[2]];
    assign ime_valid_o = valid_q[0];
    assign fme_valid_o = valid_q[1];
    assign db_valid_o  = valid_q[2];

endmodule

// File: rtl/cur_role_pkg.sv
`include "cur_cfg.svh"

package cur_role_pkg;

    // bank number 0..3
    typedef logic [$clog2(`CUR_NUM_BANKS)-1:0] bank_idx_t;

    // ****************************************
    // role of a bank in the current period
    // ****************************************
    // encoded as how far the bank sits behind the load bank,
    // so role = bank - rotation (mod 4)
    typedef enum logic [1:0] {
        ROLE_LOAD = 2'd0,   // taking the next LCU
        ROLE_IME  = 2'd3,   // loaded one period ago
        ROLE_FME  = 2'd2,   // loaded two periods ago
        ROLE_DB   = 2'd1    // oldest LCU
    } bank_role_e;

endpackage

// File: rtl/cur_rotate_ctrl.sv
`timescale 1ns/100ps

`include "cur_cfg.svh"

module cur_rotate_ctrl import cur_role_pkg::*; (
    input  logic       clk,
    input  logic       rstn,
    input  logic       start_i,                          // one pulse per LCU period
    output bank_role_e bank_role_o [`CUR_NUM_BANKS],
    output bank_idx_t  ime_bank_o,
    output bank_idx_t  fme_bank_o,
    output bank_idx_t  db_bank_o
);

    // offsets of each consumer's bank from the load bank
    localparam bank_idx_t IME_OFS = 2'd3;
    localparam bank_idx_t FME_OFS = 2'd2;
    localparam bank_idx_t DB_OFS  = 2'd1;

    bank_idx_t rot_q;   // index of the bank that loads

    // ****************************************
    // rotation count
    // ****************************************

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rot_q <= '0;
        end else if (start_i) begin
            rot_q <= rot_q + 1'b1;      // wraps at 4
        end
    end

    // ****************************************
    // role decode
    // ****************************************

    always_comb begin
        for (int b = 0; b < `CUR_NUM_BANKS; b++) begin
            bank_role_o[b] = bank_role_e'(bank_idx_t'(b) - rot_q);
        end
    end

    // inverse view for the return path
    assign ime_bank_o = rot_q + IME_OFS;
    assign fme_bank_o = rot_q + FME_OFS;
    assign db_bank_o  = rot_q + DB_OFS;

endmodule

// File: rtl/fetch_cur_luma.sv
`timescale 1ns/100ps

`include "cur_cfg.svh"

module fetch_cur_luma
    import cur_geom_pkg::*;
    import cur_role_pkg::*;
(
    input  logic       clk,
    input  logic       rstn,
    input  logic       start_i,         // rotate banks

    // external load of the next LCU
    input  logic       load_valid_i,
    input  bank_addr_t load_addr_i,
    input  blk_word_t  load_data_i,

    // integer ME
    input  logic       ime_ren_i,
    input  blk_coord_t ime_x_i,
    input  blk_coord_t ime_y_i,
    output blk_word_t  ime_pel_o,
    output logic       ime_valid_o,

    // fractional ME
    input  logic       fme_ren_i,
    input  blk_coord_t fme_x_i,
    input  blk_coord_t fme_y_i,
    output blk_word_t  fme_pel_o,
    output logic       fme_valid_o,

    // deblocking
    input  logic       db_ren_i,
    input  blk_coord_t db_x_i,
    input  blk_coord_t db_y_i,
    output blk_word_t  db_pel_o,
    output logic       db_valid_o
);

    bank_role_e bank_role [`CUR_NUM_BANKS];
    bank_idx_t  ime_bank;
    bank_idx_t  fme_bank;
    bank_idx_t  db_bank;

    cur_bank_if bank_bus [`CUR_NUM_BANKS] ();   // one per bank

    // ****************************************
    // rotation
    // ****************************************

    cur_rotate_ctrl u_rotate_ctrl (
        .clk         (clk),
        .rstn        (rstn),
        .start_i     (start_i),
        .bank_role_o (bank_role),
        .ime_bank_o  (ime_bank),
        .fme_bank_o  (fme_bank),
        .db_bank_o   (db_bank)
    );

    // ****************************************
    // banks and return path
    // ****************************************

    cur_bank_array u_bank_array (
        .clk          (clk),
        .bank_role_i  (bank_role),
        .load_valid_i (load_valid_i),
        .load_addr_i  (load_addr_i),
        .load_data_i  (load_data_i),
        .ime_ren_i    (ime_ren_i),
        .fme_ren_i    (fme_ren_i),
        .db_ren_i     (db_ren_i),
        .ime_x_i      (ime_x_i),
        .ime_y_i      (ime_y_i),
        .fme_x_i      (fme_x_i),
        .fme_y_i      (fme_y_i),
        .db_x_i       (db_x_i),
        .db_y_i       (db_y_i),
        .bank_steer   (bank_bus),
        .bank_store   (bank_bus)
    );

    cur_pel_route u_pel_route (
        .clk         (clk),
        .rstn        (rstn),
        .ime_ren_i   (ime_ren_i),
        .fme_ren_i   (fme_ren_i),
        .db_ren_i    (db_ren_i),
        .ime_bank_i  (ime_bank),
        .fme_bank_i  (fme_bank),
        .db_bank_i   (db_bank),
        .bank_sink   (bank_bus),
        .ime_pel_o   (ime_pel_o),
        .fme_pel_o   (fme_pel_o),
        .db_pel_o    (db_pel_o),
        .ime_valid_o (ime_valid_o),
        .fme_valid_o (fme_valid_o),
        .db_valid_o  (db_valid_o)
    );

endmodule

// File: verification/tb_fetch_cur_luma.sv
`timescale 1ns/100ps

`include "cur_cfg.svh"

module tb_fetch_cur_luma import cur_geom_pkg::*;;

    localparam int CLK_PERIOD = 20;
    localparam int LCU_WORDS  = `CUR_BLKS_PER_SIDE * `CUR_BLKS_PER_SIDE;
    localparam int NUM_LOADS  = 5;
    localparam int RD_LEN     = 40;   // reads per single consumer phase
    localparam int ALL_LEN    = 64;   // all three consumers together
    // loads + read phases + start pulses and idle gaps
    localparam int TEST_CYCLES = NUM_LOADS * (LCU_WORDS + 1) + 4 * (RD_LEN + 1)
                               + (ALL_LEN + 1) + 13 + 100;
    localparam int WATCHDOG_NS = (TEST_CYCLES + 200) * CLK_PERIOD;

    logic       clk;
    logic       rstn;
    logic       start_i;
    logic       load_valid_i;
    bank_addr_t load_addr_i;
    blk_word_t  load_data_i;
    logic       ime_ren_i, fme_ren_i, db_ren_i;
    blk_coord_t ime_x_i, ime_y_i, fme_x_i, fme_y_i, db_x_i, db_y_i;
    blk_word_t  ime_pel_o, fme_pel_o, db_pel_o;
    logic       ime_valid_o, fme_valid_o, db_valid_o;

    // shadow model state
    logic [127:0] shadow [`CUR_NUM_BANKS][LCU_WORDS];
    logic [1:0]   rot_m;
    logic [1:0]   ime_bank_m, fme_bank_m, db_bank_m;
    logic         exp_ime_v_q, exp_fme_v_q, exp_db_v_q;
    logic [127:0] exp_ime_q, exp_fme_q, exp_db_q;

    int    err_cnt   = 0;
    int    reads_cnt = 0;
    string test_name = "reset";

    fetch_cur_luma dut_i (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // ****************************************
    // shadow model of the rotating banks
    // ****************************************

    // ime sits 3 banks after the load bank, fme 2, db 1
    assign ime_bank_m = rot_m + 2'd3;
    assign fme_bank_m = rot_m + 2'd2;
    assign db_bank_m  = rot_m + 2'd1;

    function automatic int raster_index(input blk_coord_t x, input blk_coord_t y);
        return int'(y) * `CUR_BLKS_PER_SIDE + int'(x);
    endfunction

    always @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rot_m       <= '0;
            exp_ime_v_q <= 1'b0;
            exp_fme_v_q <= 1'b0;
            exp_db_v_q  <= 1'b0;
        end else begin
            if (load_valid_i) begin
                shadow[rot_m][load_addr_i] <= load_data_i;
            end
            if (start_i) begin
                rot_m <= rot_m + 1'b1;      // roles change after this edge
            end
            exp_ime_v_q <= ime_ren_i;
            exp_fme_v_q <= fme_ren_i;
            exp_db_v_q  <= db_ren_i;
            exp_ime_q   <= shadow[ime_bank_m][raster_index(ime_x_i, ime_y_i)];
            exp_fme_q   <= shadow[fme_bank_m][raster_index(fme_x_i, fme_y_i)];
            exp_db_q    <= shadow[db_bank_m][raster_index(db_x_i, db_y_i)];
        end
    end

    task automatic report_mismatch(input string what, input logic [127:0] exp_v,
                                   input logic [127:0] act_v);
        err_cnt++;
        $display("[FAIL] %s %s: expected %0h, actual %0h", test_name, what, exp_v, act_v);
    endtask

    // ****************************************
    // checks
    // ****************************************

    a_ime_valid: assert property (@(posedge clk) disable iff (!rstn)
        ime_valid_o === exp_ime_v_q)
        else report_mismatch("ime valid", $sampled(exp_ime_v_q), $sampled(ime_valid_o));
    a_fme_valid: assert property (@(posedge clk) disable iff (!rstn)
        fme_valid_o === exp_fme_v_q)
        else report_mismatch("fme valid", $sampled(exp_fme_v_q), $sampled(fme_valid_o));
    a_db_valid: assert property (@(posedge clk) disable iff (!rstn)
        db_valid_o === exp_db_v_q)
        else report_mismatch("db valid", $sampled(exp_db_v_q), $sampled(db_valid_o));

    a_ime_pel: assert property (@(posedge clk) disable iff (!rstn)
        exp_ime_v_q |-> ime_pel_o === exp_ime_q)
        else report_mismatch("ime pel", $sampled(exp_ime_q), $sampled(ime_pel_o));
    a_fme_pel: assert property (@(posedge clk) disable iff (!rstn)
        exp_fme_v_q |-> fme_pel_o === exp_fme_q)
        else report_mismatch("fme pel", $sampled(exp_fme_q), $sampled(fme_pel_o));
    a_db_pel: assert property (@(posedge clk) disable iff (!rstn)
        exp_db_v_q |-> db_pel_o === exp_db_q)
        else report_mismatch("db pel", $sampled(exp_db_q), $sampled(db_pel_o));

    // ****************************************
    // stimulus
    // ****************************************

    task automatic idle_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    // whole LCU in raster order, random pixels
    task automatic load_lcu();
        for (int a = 0; a < LCU_WORDS; a++) begin
            @(posedge clk);
            load_valid_i <= 1'b1;
            load_addr_i  <= bank_addr_t'(a);
            load_data_i  <= {$urandom, $urandom, $urandom, $urandom};
        end
        @(posedge clk);
        load_valid_i <= 1'b0;
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    // mask bit 0 ime, 1 fme, 2 db; start goes high on cycle start_at (-1 for never)
    task automatic read_blocks(input logic [2:0] mask, input int n, input int start_at);
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            ime_ren_i <= mask[0];
            fme_ren_i <= mask[1];
            db_ren_i  <= mask[2];
            ime_x_i   <= blk_coord_t'($urandom);
            ime_y_i   <= blk_coord_t'($urandom);
            fme_x_i   <= blk_coord_t'($urandom);
            fme_y_i   <= blk_coord_t'($urandom);
            db_x_i    <= blk_coord_t'($urandom);
            db_y_i    <= blk_coord_t'($urandom);
            start_i   <= (i == start_at);
            reads_cnt += int'(mask[0]) + int'(mask[1]) + int'(mask[2]);
        end
        @(posedge clk);
        ime_ren_i <= 1'b0;
        fme_ren_i <= 1'b0;
        db_ren_i  <= 1'b0;
        start_i   <= 1'b0;
    endtask

    initial begin
        void'($urandom(32'h948b));
        rstn         = 1'b0;
        start_i      = 1'b0;
        load_valid_i = 1'b0;
        load_addr_i  = '0;
        load_data_i  = '0;
        ime_ren_i    = 1'b0;
        fme_ren_i    = 1'b0;
        db_ren_i     = 1'b0;
        {ime_x_i, ime_y_i, fme_x_i, fme_y_i, db_x_i, db_y_i} = '0;
        repeat (2) @(posedge clk);
        rstn <= 1'b1;

        test_name = "reset_idle";
        idle_cycles(5);

        // LCU A into bank 0, then follow it through ime, fme and db
        test_name = "ime_read";
        load_lcu();
        pulse_start();
        read_blocks(3'b001, RD_LEN, -1);
        load_lcu();
        test_name = "fme_read";
        pulse_start();
        read_blocks(3'b010, RD_LEN, -1);
        load_lcu();
        test_name = "db_read";
        pulse_start();
        read_blocks(3'b100, RD_LEN, -1);
        load_lcu();

        test_name = "all_consumers";
        read_blocks(3'b111, ALL_LEN, -1);

        // back to bank 0, start lands in the middle of a read burst
        test_name = "wrap";
        pulse_start();
        load_lcu();
        read_blocks(3'b001, 12, 6);
        read_blocks(3'b001, RD_LEN, -1);
        idle_cycles(4);

        $display("reads %0d, errors %0d", reads_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        $display("watchdog expired before the stimulus finished");
        $display("TEST FAIL");
        $finish;
    end

endmodule
